/* Makefile */
# Verilator simulation of the SPI transmit master
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= spim_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim.f */
+incdir+.
spim_pkg.sv
spim_cfg_if.sv
spim_ctrl.sv
spim_txfifo.sv
spim_clkgen.sv
spim_tx.sv
spim_top.sv
spim_tb_clk.sv
spim_tb.sv

/* spim_cfg_if.sv */
// Transfer configuration between command controller and shifter
// mode and len_bits are only meaningful while en is high
`timescale 1ns/1ps
`default_nettype none
`include "spim_params.svh"

interface spim_cfg_if;

  // Held by the controller from command accept until done
  logic                       en;
  spim_pkg::spim_mode_e       mode;
  logic [`SPIM_LEN_W-1:0]     len_bits;
  // One-cycle completion from the shifter
  logic                       done;

  modport ctrl (output en, output mode, output len_bits, input done);
  modport tx   (input en, input mode, input len_bits, output done);

endinterface

`default_nettype wire

/* spim_clkgen.sv */
// Serial clock and transmit edge generator
// tx_edge runs freely from reset, sclk only while clk_en is high
// DIV must be even and at least 2
`timescale 1ns/1ps
`default_nettype none
`include "spim_params.svh"

module spim_clkgen #(
  parameter int DIV = `SPIM_CLK_DIV
) (
  input  logic clk,
  input  logic rstn,
  input  logic clk_en,   // From the shifter, registered at tx_edge
  output logic tx_edge,  // One clk cycle every DIV cycles
  output logic sclk
);

  localparam int CNTW = $clog2(DIV);

  logic [CNTW-1:0] cnt;

  // Terminal count marks the transmit edge
  assign tx_edge = (cnt == CNTW'(DIV - 1));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt  <= '0;
      sclk <= 1'b0;
    end else begin
      cnt <= tx_edge ? '0 : cnt + 1'b1;
      // Falls with the data change, rises half a period later
      if (tx_edge) sclk <= 1'b0;
      else if (clk_en && (cnt == CNTW'(DIV / 2 - 1))) sclk <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* spim_ctrl.sv */
// Command controller of the SPI transmit master
// Commands arriving while busy are dropped without notice
// Length legality is checked by assertion only, not corrected
`timescale 1ns/1ps
`default_nettype none
`include "spim_params.svh"

module spim_ctrl (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   cmd_start,   // One-cycle command strobe
  input  spim_pkg::spim_mode_e   cmd_mode,
  input  logic [`SPIM_LEN_W-1:0] cmd_len,     // Length in bits
  output logic                   busy,
  output logic                   done,        // One-cycle completion
  spim_cfg_if.ctrl               cfg
);
  import spim_pkg::*;

  spim_ctrl_state_e       state;
  spim_ctrl_state_e       state_n;
  spim_mode_e             mode_q;
  logic [`SPIM_LEN_W-1:0] len_q;
  logic                   accept;

  // Only an idle controller takes a command
  assign accept = cmd_start && (state == IDLE);

  always_comb begin
    state_n = state;
    case (state)
      IDLE:    if (cmd_start) state_n = RUN;
      // Wait for the shifter to finish the last bit period
      RUN:     if (cfg.done) state_n = FINISH;
      FINISH:  state_n = IDLE;
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      state <= state_n;
    end
  end

  // Command fields, captured once per transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      mode_q <= cmd_mode;
      len_q  <= cmd_len;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs decoded from the state register
  assign cfg.en       = (state == RUN);
  assign cfg.mode     = mode_q;
  assign cfg.len_bits = len_q;
  assign busy         = (state != IDLE);
  assign done         = (state == FINISH);

  // A taken command carries a legal length for its mode
  a_cmd_len: assert property (@(posedge clk) disable iff (!rstn)
    accept |=> (cfg.len_bits <= `SPIM_LEN_MAX) &&
               ((cfg.mode != MODE_QUAD) || (cfg.len_bits[1:0] == 2'b00)));

endmodule

`default_nettype wire

/* spim_params.svh */
// Build-time settings for the SPI transmit master
// FIFO depth must be a power of two
// Divider must be even and at least 2
// Legal lengths are 8 to SPIM_LEN_MAX bits, quad lengths a multiple of 4
`ifndef SPIM_PARAMS_SVH
`define SPIM_PARAMS_SVH

// Transmit FIFO entries, 32-bit words
`define SPIM_FIFO_DEPTH 8
// clk cycles per serial bit period
`define SPIM_CLK_DIV    4
// Bit-length field width and upper limit
`define SPIM_LEN_W      16
`define SPIM_LEN_MAX    4096

`endif

/* spim_pkg.sv */
// Shared types of the SPI transmit master
// Opcode and FSM state encodings
`default_nettype none

package spim_pkg;

  // Line mode of a transfer
  typedef enum logic [0:0] {
    MODE_SINGLE = 1'b0,
    MODE_QUAD   = 1'b1
  } spim_mode_e;

  // Command controller FSM
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FINISH
  } spim_ctrl_state_e;

  // Word shifter FSM
  typedef enum logic [0:0] {
    TX_IDLE,
    TX_SEND
  } spim_tx_state_e;

endpackage

`default_nettype wire

/* spim_tb.sv */
// Self-checking testbench for the SPI transmit master
// Random modes, lengths and words from a fixed seed
// Every word of a transfer is written before its command
// Lengths never need more words than the FIFO holds
`timescale 1ns/1ps
`default_nettype none
`include "spim_params.svh"

module spim_tb;
  import spim_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int DEPTH       = `SPIM_FIFO_DEPTH;
  localparam int N_RANDOM    = 16;
  // Six directed transfers plus the random ones
  localparam int XFERS       = N_RANDOM + 6;
  localparam int WATCHDOG_NS = XFERS * (`SPIM_LEN_MAX + 64) * `SPIM_CLK_DIV * CLK_PERIOD;

  logic                   clk;
  logic                   rstn;
  logic                   cmd_start;
  spim_mode_e             cmd_mode;
  logic [`SPIM_LEN_W-1:0] cmd_len;
  logic                   wr_en;
  logic [31:0]            wr_data;
  logic                   sclk;
  logic                   sdo0;
  logic                   sdo1;
  logic                   sdo2;
  logic                   sdo3;
  logic                   busy;
  logic                   done;
  logic                   overflow;

  // Model state, words in write order
  logic [31:0] exp_words[$];
  // Line bits seen at rising sclk, stream order
  logic        cap_bits[$];
  int          edge_count = 0;
  int          done_count = 0;
  logic        cap_quad;
  logic        upper_seen;
  logic        ovf_expected;

  spim_tb_clk #(.PERIOD(CLK_PERIOD)) u_clk (.clk(clk));

  spim_top uut (
    .clk(clk), .rstn(rstn), .cmd_start(cmd_start), .cmd_mode(cmd_mode),
    .cmd_len(cmd_len), .wr_en(wr_en), .wr_data(wr_data), .sclk(sclk),
    .sdo0(sdo0), .sdo1(sdo1), .sdo2(sdo2), .sdo3(sdo3), .busy(busy),
    .done(done), .overflow(overflow)
  );

  //////////////////////////////////////////////////////////////////////
  // Receiver model, samples the lines where a slave would
  always @(posedge sclk) begin
    edge_count = edge_count + 1;
    if (cap_quad) begin
      // Nibble MSB travels on sdo3
      cap_bits.push_back(sdo3);
      cap_bits.push_back(sdo2);
      cap_bits.push_back(sdo1);
      cap_bits.push_back(sdo0);
    end else begin
      cap_bits.push_back(sdo0);
    end
    if (sdo1 || sdo2 || sdo3) upper_seen = 1'b1;
  end

  // Done pulses, counted mid-cycle
  always @(negedge clk) begin
    if (done) done_count = done_count + 1;
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog timeout, the transfers did not complete in time");
  end

  //////////////////////////////////////////////////////////////////////
  // Failure and compare tasks
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t: %s got 0x%08h expected 0x%08h",
                               $time, name, got, exp));
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      report_failure($sformatf("mismatch at %0t: %s got %0d expected %0d",
                               $time, name, got, exp));
    end
  endtask

  task automatic compare_mode(input string name, input spim_mode_e got,
                              input spim_mode_e exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t: %s got %s expected %s",
                               $time, name, got.name(), exp.name()));
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t: %s got %b expected %b",
                               $time, name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks, all inputs change on the falling edge
  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      compare_flag("busy", busy, 1'b0);
      compare_flag("done", done, 1'b0);
      compare_flag("sclk", sclk, 1'b0);
      compare_flag("sdo0", sdo0, 1'b0);
      compare_flag("sdo1", sdo1, 1'b0);
      compare_flag("sdo2", sdo2, 1'b0);
      compare_flag("sdo3", sdo3, 1'b0);
      compare_flag("overflow", overflow, ovf_expected);
    end
  endtask

  // Words past keep are expected to be dropped by a full FIFO
  task automatic push_words(input int n, input int keep);
    logic [31:0] data;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      data    = $urandom;
      wr_en   = 1'b1;
      wr_data = data;
      if (i < keep) exp_words.push_back(data);
    end
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  task automatic prepare_transfer(input spim_mode_e mode, input int n_write,
                                  input int n_keep);
    exp_words.delete();
    cap_bits.delete();
    edge_count = 0;
    upper_seen = 1'b0;
    cap_quad   = (mode == MODE_QUAD);
    push_words(n_write, n_keep);
  endtask

  task automatic issue_command(input spim_mode_e mode, input int len);
    @(negedge clk);
    cmd_start = 1'b1;
    cmd_mode  = mode;
    cmd_len   = len[`SPIM_LEN_W-1:0];
    @(negedge clk);
    cmd_start = 1'b0;
    compare_flag("busy", busy, 1'b1);
  endtask

  // Waits for done, then checks edges, bits and line usage
  task automatic finish_transfer(input spim_mode_e mode, input int len,
                                 input int start_done);
    int          n_words;
    int          rem;
    int          idx;
    logic [31:0] got;
    logic [31:0] exp_w;
    logic [31:0] probe;
    logic        exp_upper;
    while (!done) @(negedge clk);
    @(negedge clk);
    compare_flag("done", done, 1'b0);
    compare_flag("busy", busy, 1'b0);
    expect_quiet(2 * `SPIM_CLK_DIV);
    compare_count("sclk rising edges", edge_count, (mode == MODE_QUAD) ? len / 4 : len);
    compare_count("captured bits", cap_bits.size(), len);
    compare_count("done pulses", done_count - start_done, 1);
    n_words   = (len + 31) / 32;
    rem       = len % 32;
    exp_upper = 1'b0;
    for (int w = 0; w < n_words; w++) begin
      exp_w = exp_words[w];
      // Only the top bits of a partial last word go out
      if (w == n_words - 1 && rem != 0) exp_w = exp_w & ~(32'hFFFF_FFFF >> rem);
      got = '0;
      for (int b = 0; b < 32; b++) begin
        idx   = w * 32 + b;
        got   = {got[30:0], (idx < len) ? cap_bits[idx] : 1'b0};
        probe = exp_w << b;
        // Bits 0..2 of each nibble ride on sdo3..sdo1
        if (mode == MODE_QUAD && idx < len && b % 4 != 3 && probe[31]) exp_upper = 1'b1;
      end
      compare_word($sformatf("line word %0d", w), got, exp_w);
    end
    compare_mode("line mode", upper_seen ? MODE_QUAD : MODE_SINGLE,
                 exp_upper ? MODE_QUAD : MODE_SINGLE);
  endtask

  task automatic run_transfer(input spim_mode_e mode, input int len);
    int start;
    start = done_count;
    prepare_transfer(mode, (len + 31) / 32, (len + 31) / 32);
    issue_command(mode, len);
    finish_transfer(mode, len, start);
  endtask

  //////////////////////////////////////////////////////////////////////
  initial begin : main_seq
    int         len;
    int         start;
    spim_mode_e mode;
    void'($urandom(51420));
    rstn         = 1'b0;
    cmd_start    = 1'b0;
    cmd_mode     = MODE_SINGLE;
    cmd_len      = '0;
    wr_en        = 1'b0;
    wr_data      = '0;
    cap_quad     = 1'b0;
    upper_seen   = 1'b0;
    ovf_expected = 1'b0;
    repeat (4) @(negedge clk);
    rstn = 1'b1;

    // Idle outputs with no commands
    expect_quiet(20);
    compare_count("sclk rising edges", edge_count, 0);

    // Directed lengths, whole and partial words
    run_transfer(MODE_SINGLE, 32);
    run_transfer(MODE_QUAD, 64);
    run_transfer(MODE_SINGLE, 48);
    run_transfer(MODE_QUAD, 100);

    for (int i = 0; i < N_RANDOM; i++) begin
      if ($urandom % 2 == 0) begin
        mode = MODE_SINGLE;
        len  = 8 + int'($urandom % (DEPTH * 32 - 7));
      end else begin
        mode = MODE_QUAD;
        len  = 4 * (2 + int'($urandom % (DEPTH * 8 - 1)));
      end
      run_transfer(mode, len);
    end

    // Second command during a transfer is dropped
    start = done_count;
    prepare_transfer(MODE_SINGLE, 3, 3);
    issue_command(MODE_SINGLE, 96);
    repeat (10 * `SPIM_CLK_DIV) @(negedge clk);
    issue_command(MODE_QUAD, 16);
    finish_transfer(MODE_SINGLE, 96, start);
    expect_quiet(8 * `SPIM_CLK_DIV);
    compare_count("done pulses", done_count - start, 1);

    // One word too many, overflow sticks, first DEPTH words survive
    start = done_count;
    prepare_transfer(MODE_SINGLE, DEPTH + 1, DEPTH);
    ovf_expected = 1'b1;
    compare_flag("overflow", overflow, 1'b1);
    expect_quiet(4);
    issue_command(MODE_SINGLE, DEPTH * 32);
    finish_transfer(MODE_SINGLE, DEPTH * 32, start);

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* spim_tb_clk.sv */
// Free-running testbench clock, starts low
// PERIOD is in ns and should be even
`timescale 1ns/1ps
`default_nettype none

module spim_tb_clk #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial clk = 1'b0;

  // Half period low, half high
  always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* spim_top.sv */
// Transmit-only SPI master, single or quad lines
// No chip select, no receive path, sclk idles low
// Caller must fill the FIFO before or during a transfer
`timescale 1ns/1ps
`default_nettype none
`include "spim_params.svh"

module spim_top (
  input  logic                   clk,
  input  logic                   rstn,
  // Command strobe, ignored while busy
  input  logic                   cmd_start,
  input  spim_pkg::spim_mode_e   cmd_mode,
  input  logic [`SPIM_LEN_W-1:0] cmd_len,
  // Word push strobe
  input  logic                   wr_en,
  input  logic [31:0]            wr_data,
  // Serial side
  output logic                   sclk,
  output logic                   sdo0,
  output logic                   sdo1,
  output logic                   sdo2,
  output logic                   sdo3,
  // Status
  output logic                   busy,
  output logic                   done,
  output logic                   overflow
);

  logic [31:0] word;
  logic        word_valid;
  logic        word_ready;
  logic        tx_edge;
  logic        clk_en;

  spim_cfg_if cfg_if ();

  // Producer side
  spim_ctrl u_ctrl (
    .clk(clk), .rstn(rstn), .cmd_start(cmd_start), .cmd_mode(cmd_mode),
    .cmd_len(cmd_len), .busy(busy), .done(done), .cfg(cfg_if)
  );

  // Buffer
  spim_txfifo u_txfifo (
    .clk(clk), .rstn(rstn), .wr_en(wr_en), .wr_data(wr_data),
    .word_ready(word_ready), .word(word), .word_valid(word_valid),
    .overflow(overflow)
  );

  // Consumer side, edge generator and shifter
  spim_clkgen u_clkgen (
    .clk(clk), .rstn(rstn), .clk_en(clk_en), .tx_edge(tx_edge), .sclk(sclk)
  );

  spim_tx u_tx (
    .clk(clk), .rstn(rstn), .tx_edge(tx_edge), .word(word),
    .word_valid(word_valid), .word_ready(word_ready), .clk_en(clk_en),
    .sdo0(sdo0), .sdo1(sdo1), .sdo2(sdo2), .sdo3(sdo3), .cfg(cfg_if)
  );

endmodule

`default_nettype wire

/* spim_tx.sv */
// Transmit word shifter sending MSB first on one or four lines
// Words are taken from the FIFO at each 32-bit boundary
// A FIFO running dry mid-transfer ends the transfer early with done
// Quad lengths are assumed to be a multiple of 4
`timescale 1ns/1ps
`default_nettype none
`include "spim_params.svh"

module spim_tx (
  input  logic        clk,
  input  logic        rstn,
  input  logic        tx_edge,     // Bit period boundary
  input  logic [31:0] word,        // FIFO head entry
  input  logic        word_valid,
  output logic        word_ready,  // Pop in the same cycle as the load
  output logic        clk_en,      // Serial clock gate
  output logic        sdo0,
  output logic        sdo1,
  output logic        sdo2,
  output logic        sdo3,
  spim_cfg_if.tx      cfg
);
  import spim_pkg::*;

  localparam int LW = `SPIM_LEN_W;

  spim_tx_state_e state;
  spim_tx_state_e state_n;
  logic [31:0]    shreg;
  logic [31:0]    shreg_n;
  logic [LW-1:0]  cnt;        // Bit periods put on the lines
  logic [LW-1:0]  cnt_n;
  logic [LW-1:0]  target;     // Periods in this transfer
  logic           quad;
  logic           boundary;   // Current word fully sent
  logic           last;
  logic           done_q;

  assign quad     = (cfg.mode == MODE_QUAD);
  // Four bits per period in quad mode
  assign target   = quad ? {2'b00, cfg.len_bits[LW-1:2]} : cfg.len_bits;
  assign boundary = quad ? (cnt[2:0] == 3'b000) : (cnt[4:0] == 5'b00000);

  //////////////////////////////////////////////////////////////////////
  // Next-state logic acting only at tx_edge
  always_comb begin
    state_n    = state;
    shreg_n    = shreg;
    cnt_n      = cnt;
    word_ready = 1'b0;
    last       = 1'b0;
    case (state)
      TX_IDLE: begin
        // First word goes straight onto the lines
        if (tx_edge && cfg.en && word_valid) begin
          word_ready = 1'b1;
          shreg_n    = word;
          cnt_n      = LW'(1);
          state_n    = TX_SEND;
        end
      end
      TX_SEND: begin
        if (tx_edge) begin
          if (cnt == target) begin
            last    = 1'b1;
            state_n = TX_IDLE;
          end else if (boundary) begin
            cnt_n = cnt + 1'b1;
            if (word_valid) begin
              word_ready = 1'b1;
              shreg_n    = word;
            end else begin
              // Underrun stops the transfer early
              last    = 1'b1;
              state_n = TX_IDLE;
            end
          end else begin
            cnt_n   = cnt + 1'b1;
            shreg_n = quad ? {shreg[27:0], 4'b0000} : {shreg[30:0], 1'b0};
          end
        end
      end
      default: state_n = TX_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state  <= TX_IDLE;
      cnt    <= '0;
      done_q <= 1'b0;
      clk_en <= 1'b0;
      sdo0   <= 1'b0;
      sdo1   <= 1'b0;
      sdo2   <= 1'b0;
      sdo3   <= 1'b0;
    end else begin
      state  <= state_n;
      cnt    <= cnt_n;
      done_q <= last;
      // Lines and clock gate move only at the transmit edge
      if (tx_edge) begin
        clk_en <= (state_n == TX_SEND);
        if (state_n == TX_SEND) begin
          sdo0 <= quad ? shreg_n[28] : shreg_n[31];
          sdo1 <= quad && shreg_n[29];
          sdo2 <= quad && shreg_n[30];
          sdo3 <= quad && shreg_n[31];
        end else begin
          sdo0 <= 1'b0;
          sdo1 <= 1'b0;
          sdo2 <= 1'b0;
          sdo3 <= 1'b0;
        end
      end
    end
  end

  // Shift register follows the next-state logic
  always_ff @(posedge clk) begin
    shreg <= shreg_n;
  end

  assign cfg.done = done_q;

  // Pop only with a word present, and never two cycles in a row
  a_pop_valid: assert property (@(posedge clk) disable iff (!rstn)
    word_ready |-> word_valid ##1 !word_ready);

endmodule

`default_nettype wire

/* spim_txfifo.sv */
// Transmit word FIFO showing the head entry without look-ahead
// Pushes into a full FIFO are lost and set overflow until reset
// DEPTH must be a power of two
`timescale 1ns/1ps
`default_nettype none
`include "spim_params.svh"

module spim_txfifo #(
  parameter int DEPTH = `SPIM_FIFO_DEPTH
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        wr_en,       // One-cycle push strobe
  input  logic [31:0] wr_data,
  input  logic        word_ready,  // Pop from the shifter
  output logic [31:0] word,
  output logic        word_valid,
  output logic        overflow
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  logic [31:0]   mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          push;
  logic          pop;

  assign full       = (count == CW'(DEPTH));
  assign push       = wr_en && !full;
  assign pop        = word_ready && word_valid;
  assign word_valid = (count != '0);
  assign word       = mem[rd_ptr];

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous push and pop leave the count unchanged
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
      if (wr_en && full) overflow <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= wr_data;
  end

  // Shifter never pops an empty FIFO
  a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
    word_ready |-> (count != '0));
  // Occupancy stays within DEPTH and matches the pointer distance
  a_count_max: assert property (@(posedge clk) disable iff (!rstn)
    (count <= CW'(DEPTH)) && (AW'(count) == AW'(wr_ptr - rd_ptr)));

endmodule

`default_nettype wire
